// ==== Makefile ====
# Verilator build and run for the APU subsystem testbench
TOP = tb_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard logic/*.sv tb/*.sv)
	verilator --binary --assert -j 0 --top-module $(TOP) -f project.f

# Assertion errors keep the run going so the summary is printed
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

// ==== logic/apu_disp.sv ====
// APU dispatcher
// Tracks up to two unreturned instructions, reports register
// dependencies against them, raises the stall causes and returns
// each result with the destination address it belongs to
`timescale 1ns/10ps

module apu_disp
  import apu_pkg::*;
  import reg_pkg::*;
#(
  parameter int unsigned NUM_REGS_W = 6
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Core request side
  input  logic                  enable_i,
  input  apu_req_t              apu_req_i,
  input  apu_lat_e              apu_lat_i,
  input  logic [NUM_REGS_W-1:0] apu_waddr_i,
  input  rd_query_t             rd_query_i,
  input  wr_query_t             wr_query_i,
  // Core response side
  output logic                  valid_o,
  output apu_rsp_t              apu_rsp_o,
  output logic [NUM_REGS_W-1:0] apu_waddr_o,
  output logic                  read_dep_o,
  output logic                  write_dep_o,
  output logic                  stall_o,
  output logic                  active_o,
  output logic                  stall_type_o,
  output logic                  stall_nack_o,
  // Shared APU bus
  output logic                  bus_req_o,
  output apu_req_t              bus_req_data_o,
  input  logic                  bus_gnt_i,
  input  logic                  bus_valid_i,
  input  apu_rsp_t              bus_rsp_i
);

  logic [NUM_REGS_W-1:0] addr_inflight_q, addr_waiting_q;
  logic                  valid_inflight_q, valid_waiting_q;
  logic                  valid_req, req_accepted, active;
  logic                  returned_req, returned_inflight, returned_waiting;
  logic                  stall_full, stall_type, stall_nack;
  apu_lat_e              apu_lat_q;
  logic [2:0]            rd_req, rd_inflight, rd_waiting;
  logic [1:0]            wr_req, wr_inflight, wr_waiting;

  // Request goes out unless blocked by a full or type stall
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign req_accepted = valid_req & bus_gnt_i;
  assign active       = valid_inflight_q | valid_waiting_q;

  // Oldest outstanding entry is the one that returns
  assign returned_req      = valid_req & bus_valid_i & ~valid_inflight_q & ~valid_waiting_q;
  assign returned_inflight = valid_inflight_q & bus_valid_i & ~valid_waiting_q;
  assign returned_waiting  = valid_waiting_q & bus_valid_i;

  //////////////////////////////
  // Slot registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight_q <= 1'b0;
      valid_waiting_q  <= 1'b0;
    end else if (req_accepted && !returned_req) begin
      valid_inflight_q <= 1'b1;
      // Older entry still pending moves to the waiting slot
      valid_waiting_q  <= valid_inflight_q & ~returned_inflight;
    end else if (returned_inflight) begin
      valid_inflight_q <= 1'b0;
    end else if (returned_waiting) begin
      valid_waiting_q <= 1'b0;
    end
  end

  // Destination addresses are qualified by the valid bits
  always_ff @(posedge clk_i) begin
    if (req_accepted && !returned_req) begin
      addr_inflight_q <= apu_waddr_i;
      addr_waiting_q  <= addr_inflight_q;
    end
  end

  // Latency class of the last request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      apu_lat_q <= LAT_SINGLE;
    end else if (valid_req) begin
      apu_lat_q <= apu_lat_i;
    end
  end

  //////////////////////////////
  // Dependency checks
  //////////////////////////////

  // Register zero never creates a hazard
  for (genvar i = 0; i < 3; i++) begin : gen_rd_dep
    logic                  hit;
    logic [NUM_REGS_W-1:0] a;
    assign a              = NUM_REGS_W'(rd_query_i.addr[i]);
    assign hit            = rd_query_i.valid[i] & (|rd_query_i.addr[i]);
    assign rd_req[i]      = hit & (a == apu_waddr_i);
    assign rd_inflight[i] = hit & (a == addr_inflight_q);
    assign rd_waiting[i]  = hit & (a == addr_waiting_q);
  end

  for (genvar i = 0; i < 2; i++) begin : gen_wr_dep
    logic                  hit;
    logic [NUM_REGS_W-1:0] a;
    assign a              = NUM_REGS_W'(wr_query_i.addr[i]);
    assign hit            = wr_query_i.valid[i] & (|wr_query_i.addr[i]);
    assign wr_req[i]      = hit & (a == apu_waddr_i);
    assign wr_inflight[i] = hit & (a == addr_inflight_q);
    assign wr_waiting[i]  = hit & (a == addr_waiting_q);
  end

  // Entries returning this cycle no longer count
  assign read_dep_o  = (|rd_req & valid_req & ~returned_req)
                     | (|rd_inflight & valid_inflight_q & ~returned_inflight)
                     | (|rd_waiting & valid_waiting_q & ~returned_waiting);
  assign write_dep_o = (|wr_req & valid_req & ~returned_req)
                     | (|wr_inflight & valid_inflight_q & ~returned_inflight)
                     | (|wr_waiting & valid_waiting_q & ~returned_waiting);

  //////////////////////////////
  // Stalls
  //////////////////////////////

  assign stall_full = valid_inflight_q & valid_waiting_q;
  // While active, only classes that cannot overtake may issue
  assign stall_type = enable_i & active &
                      ((apu_lat_i == LAT_ONE) |
                       ((apu_lat_i == LAT_PIPE) & (apu_lat_q == LAT_MULTI)) |
                       (apu_lat_i == LAT_MULTI));
  assign stall_nack = valid_req & ~bus_gnt_i;

  assign stall_o      = stall_full | stall_type | stall_nack;
  assign stall_type_o = stall_type;
  assign stall_nack_o = stall_nack;
  assign active_o     = active;

  // Bus request and response
  assign bus_req_o      = valid_req;
  assign bus_req_data_o = apu_req_i;
  assign valid_o        = bus_valid_i;
  assign apu_rsp_o      = bus_rsp_i;

  // Destination of the returning instruction
  always_comb begin
    apu_waddr_o = '0;
    if (returned_waiting) begin
      apu_waddr_o = addr_waiting_q;
    end else if (returned_inflight) begin
      apu_waddr_o = addr_inflight_q;
    end else if (returned_req) begin
      apu_waddr_o = apu_waddr_i;
    end
  end

endmodule

// ==== logic/apu_div_unit.sv ====
// APU divider unit
// Iterative restoring unsigned divider, one quotient bit per cycle,
// returns quotient or remainder and flags a zero divisor
`timescale 1ns/10ps

module apu_div_unit
  import apu_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  apu_req_t req_data_i,
  output logic     gnt_o,
  output logic     valid_o,
  output apu_rsp_t rsp_o
);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

  div_state_e        state_q;
  logic [4:0]        cnt_q;
  logic              valid_q;
  logic              accept;
  logic [WORD_W-1:0] rem_q, quo_q, divisor_q;
  logic              rem_sel_q, dz_q;
  logic [WORD_W:0]   shifted;
  logic [WORD_W+1:0] trial;
  logic              fits;
  apu_rsp_t          rsp_q;

  // One operation at a time
  assign gnt_o  = (state_q == DIV_IDLE);
  assign accept = req_i & gnt_o;

  // Shift in the next dividend bit and try the subtraction
  assign shifted = {rem_q, quo_q[WORD_W-1]};
  assign trial   = {1'b0, shifted} - {2'b00, divisor_q};
  assign fits    = ~trial[WORD_W+1];

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      unique case (state_q)
        DIV_IDLE: begin
          if (accept) begin
            state_q <= DIV_RUN;
            cnt_q   <= '0;
          end
        end
        DIV_RUN: begin
          // 32 iterations
          cnt_q <= cnt_q + 5'd1;
          if (cnt_q == 5'd31) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          valid_q <= 1'b1;
          state_q <= DIV_IDLE;
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Zero divisor never borrows, so the quotient ends all ones
  // and the remainder ends equal to the dividend
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rem_q     <= '0;
      quo_q     <= req_data_i.operand_a;
      divisor_q <= req_data_i.operand_b;
      rem_sel_q <= (req_data_i.op == OP_REM);
      dz_q      <= (req_data_i.operand_b == '0);
    end else if (state_q == DIV_RUN) begin
      quo_q <= {quo_q[WORD_W-2:0], fits};
      rem_q <= fits ? trial[WORD_W-1:0] : shifted[WORD_W-1:0];
    end
    if (state_q == DIV_DONE) begin
      rsp_q.result  <= rem_sel_q ? rem_q : quo_q;
      rsp_q.flag_dz <= dz_q;
    end
  end

  assign valid_o = valid_q;
  assign rsp_o   = rsp_q;

endmodule

// ==== logic/apu_interconnect.sv ====
// APU interconnect
// Steers bus requests to the multiplier or divider by unit type and
// arbitrates the single response channel, multiplier first
`timescale 1ns/10ps

module apu_interconnect
  import apu_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // Dispatcher side
  input  logic     bus_req_i,
  input  apu_req_t bus_req_data_i,
  output logic     bus_gnt_o,
  output logic     bus_valid_o,
  output apu_rsp_t bus_rsp_o,
  // Multiplier side
  output logic     mult_req_o,
  output apu_req_t mult_req_data_o,
  input  logic     mult_gnt_i,
  input  logic     mult_valid_i,
  input  apu_rsp_t mult_rsp_i,
  // Divider side
  output logic     div_req_o,
  output apu_req_t div_req_data_o,
  input  logic     div_gnt_i,
  input  logic     div_valid_i,
  input  apu_rsp_t div_rsp_i
);

  logic     to_div;
  logic     buf_valid_q, buf_load;
  apu_rsp_t buf_rsp_q;

  // Request steering
  assign to_div          = (bus_req_data_i.unit == UNIT_DIV);
  assign mult_req_o      = bus_req_i & ~to_div;
  assign div_req_o       = bus_req_i & to_div;
  assign mult_req_data_o = bus_req_data_i;
  assign div_req_data_o  = bus_req_data_i;
  assign bus_gnt_o       = to_div ? div_gnt_i : mult_gnt_i;

  // Divider result parks here while the channel is taken
  assign buf_load = div_valid_i & (mult_valid_i | buf_valid_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (buf_load) begin
      buf_valid_q <= 1'b1;
    end else if (!mult_valid_i) begin
      // Drained this cycle
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_load) begin
      buf_rsp_q <= div_rsp_i;
    end
  end

  // Response priority: multiplier, buffer, divider
  always_comb begin
    bus_valid_o = 1'b0;
    bus_rsp_o   = mult_rsp_i;
    if (mult_valid_i) begin
      bus_valid_o = 1'b1;
    end else if (buf_valid_q) begin
      bus_valid_o = 1'b1;
      bus_rsp_o   = buf_rsp_q;
    end else if (div_valid_i) begin
      bus_valid_o = 1'b1;
      bus_rsp_o   = div_rsp_i;
    end
  end

endmodule

// ==== logic/apu_mult_unit.sv ====
// APU multiplier unit
// Two-stage pipelined 32x32 multiplier, low word for OP_MUL and
// signed or unsigned high word for OP_MULH
`timescale 1ns/10ps

module apu_mult_unit
  import apu_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  apu_req_t req_data_i,
  output logic     gnt_o,
  output logic     valid_o,
  output apu_rsp_t rsp_o
);

  logic                       accept;
  logic                       ext_a, ext_b;
  logic signed [WORD_W:0]     op_a, op_b;
  logic signed [2*WORD_W+1:0] prod;
  logic                       s1_valid_q, s1_high_q;
  logic [2*WORD_W-1:0]        s1_prod_q;
  logic                       s2_valid_q;
  apu_rsp_t                   s2_rsp_q;

  // Fully pipelined, a new operation every cycle
  assign gnt_o  = 1'b1;
  assign accept = req_i & gnt_o;

  // Sign extension only in signed mode
  assign ext_a = req_data_i.flag_signed & req_data_i.operand_a[WORD_W-1];
  assign ext_b = req_data_i.flag_signed & req_data_i.operand_b[WORD_W-1];
  assign op_a  = $signed({ext_a, req_data_i.operand_a});
  assign op_b  = $signed({ext_b, req_data_i.operand_b});
  assign prod  = op_a * op_b;

  // Stage valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= accept;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Stage 1 holds the full product, stage 2 the selected word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_prod_q <= prod[2*WORD_W-1:0];
      s1_high_q <= (req_data_i.op == OP_MULH);
    end
    if (s1_valid_q) begin
      s2_rsp_q.result  <= s1_high_q ? s1_prod_q[2*WORD_W-1:WORD_W] : s1_prod_q[WORD_W-1:0];
      s2_rsp_q.flag_dz <= 1'b0;
    end
  end

  assign valid_o = s2_valid_q;
  assign rsp_o   = s2_rsp_q;

endmodule

// ==== logic/apu_pkg.sv ====
// APU bus package
// Request and response structs for the shared APU bus, plus the
// unit type, opcode and latency-class encodings used on it
package apu_pkg;

  // Data word width on the bus
  localparam int unsigned WORD_W = 32;

  // Target unit, decoded by the interconnect
  typedef enum logic {
    UNIT_MULT = 1'b0,
    UNIT_DIV  = 1'b1
  } apu_type_e;

  // Operation within the unit
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_MULH = 2'd1,
    OP_DIV  = 2'd2,
    OP_REM  = 2'd3
  } apu_op_e;

  // Latency class, used by the dispatcher for ordering
  typedef enum logic [1:0] {
    LAT_SINGLE = 2'd0,
    LAT_ONE    = 2'd1,
    LAT_PIPE   = 2'd2,
    LAT_MULTI  = 2'd3
  } apu_lat_e;

  // Request channel, 68 bits
  typedef struct packed {
    apu_type_e         unit;
    apu_op_e           op;
    logic [WORD_W-1:0] operand_a;
    logic [WORD_W-1:0] operand_b;
    // Downstream flag, signed mode
    logic              flag_signed;
  } apu_req_t;

  // Response channel, 33 bits
  typedef struct packed {
    logic [WORD_W-1:0] result;
    // Upstream flag, divide by zero
    logic              flag_dz;
  } apu_rsp_t;

endpackage

// ==== logic/apu_top.sv ====
// APU subsystem top
// Dispatcher on the core side, interconnect on the shared bus,
// pipelined multiplier and iterative divider behind it
`timescale 1ns/10ps

module apu_top
  import apu_pkg::*;
  import reg_pkg::*;
#(
  parameter int unsigned NUM_REGS_W = 6
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  enable_i,
  input  apu_req_t              apu_req_i,
  input  apu_lat_e              apu_lat_i,
  input  logic [NUM_REGS_W-1:0] apu_waddr_i,
  input  rd_query_t             rd_query_i,
  input  wr_query_t             wr_query_i,
  output logic                  valid_o,
  output apu_rsp_t              apu_rsp_o,
  output logic [NUM_REGS_W-1:0] apu_waddr_o,
  output logic                  read_dep_o,
  output logic                  write_dep_o,
  output logic                  stall_o,
  output logic                  active_o,
  output logic                  stall_type_o,
  output logic                  stall_nack_o
);

  // Shared bus
  logic     bus_req, bus_gnt, bus_valid;
  apu_req_t bus_req_data;
  apu_rsp_t bus_rsp;
  // Unit links
  logic     mult_req, mult_gnt, mult_valid;
  logic     div_req, div_gnt, div_valid;
  apu_req_t mult_req_data, div_req_data;
  apu_rsp_t mult_rsp, div_rsp;

  apu_disp #(
    .NUM_REGS_W(NUM_REGS_W)
  ) u_disp (
    .clk_i, .rst_ni, .enable_i, .apu_req_i, .apu_lat_i, .apu_waddr_i,
    .rd_query_i, .wr_query_i, .valid_o, .apu_rsp_o, .apu_waddr_o,
    .read_dep_o, .write_dep_o, .stall_o, .active_o, .stall_type_o, .stall_nack_o,
    .bus_req_o      (bus_req),
    .bus_req_data_o (bus_req_data),
    .bus_gnt_i      (bus_gnt),
    .bus_valid_i    (bus_valid),
    .bus_rsp_i      (bus_rsp)
  );

  apu_interconnect u_icn (
    .clk_i, .rst_ni,
    .bus_req_i (bus_req), .bus_req_data_i (bus_req_data), .bus_gnt_o (bus_gnt),
    .bus_valid_o (bus_valid), .bus_rsp_o (bus_rsp),
    .mult_req_o (mult_req), .mult_req_data_o (mult_req_data), .mult_gnt_i (mult_gnt),
    .mult_valid_i (mult_valid), .mult_rsp_i (mult_rsp),
    .div_req_o (div_req), .div_req_data_o (div_req_data), .div_gnt_i (div_gnt),
    .div_valid_i (div_valid), .div_rsp_i (div_rsp)
  );

  apu_mult_unit u_mult (
    .clk_i, .rst_ni,
    .req_i (mult_req), .req_data_i (mult_req_data), .gnt_o (mult_gnt),
    .valid_o (mult_valid), .rsp_o (mult_rsp)
  );

  apu_div_unit u_div (
    .clk_i, .rst_ni,
    .req_i (div_req), .req_data_i (div_req_data), .gnt_o (div_gnt),
    .valid_o (div_valid), .rsp_o (div_rsp)
  );

endmodule

// ==== logic/reg_pkg.sv ====
// Core-side register package
// Register address and dependency query types
package reg_pkg;

  // Address width of the core register file
  localparam int unsigned REG_ADDR_W = 6;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Up to three source registers of the decoded instruction
  typedef struct packed {
    reg_addr_t [2:0] addr;
    logic [2:0]      valid;
  } rd_query_t;

  // Up to two destination registers of the decoded instruction
  typedef struct packed {
    reg_addr_t [1:0] addr;
    logic [1:0]      valid;
  } wr_query_t;

endpackage

// ==== project.f ====
logic/apu_pkg.sv
logic/reg_pkg.sv
logic/apu_disp.sv
logic/apu_mult_unit.sv
logic/apu_div_unit.sv
logic/apu_interconnect.sv
logic/apu_top.sv
tb/apu_disp_chk.sv
tb/apu_monitor.sv
tb/tb_top.sv

// ==== tb/apu_disp_chk.sv ====
// Dispatcher checker
// Concurrent assertions on the slot and stall rules of the bound dispatcher
`timescale 1ns/10ps

module apu_disp_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic inflight_valid_i,
  input logic waiting_valid_i,
  input logic rsp_valid_i,
  input logic bus_req_i,
  input logic bus_gnt_i
);

  // Failed assertions so far
  int fail_count = 0;

  // Instructions accepted on the bus and not yet answered
  logic [2:0] outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(bus_req_i & bus_gnt_i) - 3'(rsp_valid_i);
    end
  end

  // Every response belongs to an outstanding instruction
  a_rsp_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> (inflight_valid_i || waiting_valid_i))
    else begin
      $error("Response arrived with no instruction outstanding");
      fail_count++;
    end

  // Waiting slot fills only behind the in-flight slot
  a_slot_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    waiting_valid_i |-> inflight_valid_i)
    else begin
      $error("Waiting slot valid while in-flight slot is empty");
      fail_count++;
    end

  // Two unanswered instructions on the bus fill both slots
  a_no_req_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i |-> (outstanding_q < 3'd2))
    else begin
      $error("Bus request raised while both slots are full");
      fail_count++;
    end

endmodule

// ==== tb/apu_monitor.sv ====
// APU monitor
// Watches the APU top ports, models accepted instructions and the
// dispatcher slots, compares results, dependencies and stalls
`timescale 1ns/10ps

module apu_monitor
  import apu_pkg::*;
  import reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      done_i,
  input  logic      enable_i,
  input  apu_req_t  req_i,
  input  apu_lat_e  lat_i,
  input  reg_addr_t waddr_i,
  input  rd_query_t rd_query_i,
  input  wr_query_t wr_query_i,
  input  logic      valid_i,
  input  apu_rsp_t  rsp_i,
  input  reg_addr_t waddr_ret_i,
  input  logic      read_dep_i,
  input  logic      write_dep_i,
  input  logic      stall_i,
  input  logic      active_i,
  input  logic      stall_type_i,
  input  logic      stall_nack_i,
  output int        pending_o,
  output int        returned_o,
  output int        check_count_o,
  output int        err_count_o
);

  localparam int T_MULT  = 0;
  localparam int T_DIV   = 1;
  localparam int T_ORDER = 2;
  localparam int T_DEP   = 3;
  localparam int T_STALL = 4;
  localparam int T_IDLE  = 5;

  // One accepted instruction and what it should return
  typedef struct packed {
    logic        is_div;
    reg_addr_t   waddr;
    logic [31:0] result;
    logic        dz;
    int          acc_cyc;
  } exp_t;

  exp_t pend [$];
  exp_t e;
  int   checks [6];
  int   errors [6];
  int   cyc, lat;
  logic first_req_seen, last_was_div;
  logic type_hit, req_live, exp_rd, exp_wr;

  initial begin
    foreach (checks[t]) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    cyc            = 0;
    first_req_seen = 1'b0;
    last_was_div   = 1'b0;
    pending_o      = 0;
    returned_o     = 0;
    check_count_o  = 0;
    err_count_o    = 0;
  end

  function automatic string name_of(input int t);
    case (t)
      T_MULT:  return "mult_result";
      T_DIV:   return "div_result";
      T_ORDER: return "order";
      T_DEP:   return "dependency";
      T_STALL: return "stall";
      default: return "reset_idle";
    endcase
  endfunction

  task automatic check_word(input int t, input logic [31:0] exp, input logic [31:0] act);
    checks[t]++;
    check_count_o++;
    if (exp !== act) begin
      errors[t]++;
      err_count_o++;
      $display("Error %s: expected %h, actual %h", name_of(t), exp, act);
    end
  endtask

  task automatic check_flag(input int t, input logic exp, input logic act);
    check_word(t, {31'h0, exp}, {31'h0, act});
  endtask

  task automatic report_failure(input int t, input string msg);
    checks[t]++;
    errors[t]++;
    check_count_o++;
    err_count_o++;
    $display("%s: %s at cycle %0d", name_of(t), msg, cyc);
  endtask

  task automatic print_test(input int t);
    $display("Test %s: %0d checks, %0d errors", name_of(t), checks[t], errors[t]);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Low word, or high word signed or unsigned, quotient or remainder
  function automatic exp_t expect_of(input apu_req_t r, input reg_addr_t wa);
    exp_t        x;
    logic [63:0] ea, eb, p;
    x        = '0;
    x.waddr  = wa;
    x.is_div = (r.unit == UNIT_DIV);
    if (x.is_div) begin
      if (r.operand_b == 32'h0) begin
        x.result = (r.op == OP_REM) ? r.operand_a : 32'hffff_ffff;
        x.dz     = 1'b1;
      end else begin
        x.result = (r.op == OP_REM) ? r.operand_a % r.operand_b : r.operand_a / r.operand_b;
      end
    end else begin
      ea       = r.flag_signed ? {{32{r.operand_a[31]}}, r.operand_a} : {32'h0, r.operand_a};
      eb       = r.flag_signed ? {{32{r.operand_b[31]}}, r.operand_b} : {32'h0, r.operand_b};
      p        = ea * eb;
      x.result = (r.op == OP_MULH) ? p[63:32] : p[31:0];
    end
    return x;
  endfunction

  // Address owned by the offered request or an entry not returning now
  function automatic logic addr_busy(input reg_addr_t a, input logic live, input logic ret);
    logic hit;
    hit = live && (a == waddr_i);
    for (int j = (ret ? 1 : 0); j < pend.size(); j++) begin
      if (pend[j].waddr == a) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  //////////////////////////////
  // Compare at the falling edge
  //////////////////////////////

  always @(negedge clk_i) begin
    if (!first_req_seen) begin
      if (rst_ni && enable_i) begin
        first_req_seen = 1'b1;
        print_test(T_IDLE);
      end else begin
        check_flag(T_IDLE, 1'b0, valid_i);
        check_flag(T_IDLE, 1'b0, stall_i);
        check_flag(T_IDLE, 1'b0, active_i);
      end
    end
    if (rst_ni) begin
      // Divide while active, or multiply behind a divide
      type_hit = enable_i && (pend.size() > 0) &&
                 (lat_i == LAT_MULTI || (lat_i == LAT_PIPE && last_was_div));
      req_live = enable_i && (pend.size() < 2) && !type_hit;
      exp_rd   = 1'b0;
      exp_wr   = 1'b0;
      for (int i = 0; i < 3; i++) begin
        if (rd_query_i.valid[i] && rd_query_i.addr[i] != '0) begin
          exp_rd |= addr_busy(rd_query_i.addr[i], req_live, valid_i);
        end
      end
      for (int i = 0; i < 2; i++) begin
        if (wr_query_i.valid[i] && wr_query_i.addr[i] != '0) begin
          exp_wr |= addr_busy(wr_query_i.addr[i], req_live, valid_i);
        end
      end
      check_flag(T_DEP, exp_rd, read_dep_i);
      check_flag(T_DEP, exp_wr, write_dep_i);
      check_flag(T_STALL, type_hit, stall_type_i);
      check_flag(T_STALL, (pend.size() == 2) || type_hit, stall_i);
      check_flag(T_STALL, pend.size() > 0, active_i);
      // The divider is idle whenever a divide may issue
      check_flag(T_STALL, 1'b0, stall_nack_i);

      // Oldest entry returns first
      if (valid_i) begin
        if (pend.size() == 0) begin
          report_failure(T_ORDER, "Result returned with no instruction outstanding");
        end else begin
          e   = pend.pop_front();
          lat = cyc - e.acc_cyc;
          check_word(T_ORDER, 32'(e.waddr), 32'(waddr_ret_i));
          if (e.is_div) begin
            check_word(T_DIV, e.result, rsp_i.result);
            check_flag(T_DIV, e.dz, rsp_i.flag_dz);
            // No multiply overlaps a divide, so the channel is always free
            check_word(T_DIV, 32'd34, lat);
          end else begin
            check_word(T_MULT, e.result, rsp_i.result);
            check_flag(T_MULT, e.dz, rsp_i.flag_dz);
            check_word(T_MULT, 32'd2, lat);
          end
          returned_o++;
        end
      end

      // Acceptance at the coming rising edge
      if (enable_i && !stall_i) begin
        if (active_i && (lat_i == LAT_MULTI || last_was_div)) begin
          report_failure(T_STALL, "Instruction accepted before active_o fell");
        end
        e         = expect_of(req_i, waddr_i);
        e.acc_cyc = cyc;
        pend.push_back(e);
      end
      if (req_live) begin
        last_was_div = (lat_i == LAT_MULTI);
      end
      pending_o = pend.size();
    end
    cyc++;
  end

  always @(posedge done_i) begin
    for (int t = T_MULT; t <= T_STALL; t++) begin
      print_test(t);
    end
    if (!first_req_seen) begin
      print_test(T_IDLE);
    end
  end

endmodule

// ==== tb/tb_top.sv ====
// APU subsystem testbench
// Seeded random multiply and divide stream with dependency queries,
// held under stall, checked by the monitor and bound assertions
`timescale 1ns/10ps

module tb_top
  import apu_pkg::*;
  import reg_pkg::*;
();

  localparam int NUM_REGS_W = 6;
  localparam int NUM_INSTR  = 200;
  // Worst case per instruction plus reset and drain margin
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 500;

  logic      clk, rst_n, enable, done;
  apu_req_t  req;
  apu_lat_e  lat;
  reg_addr_t waddr;
  rd_query_t rd_q;
  wr_query_t wr_q;
  logic      valid, read_dep, write_dep, stall, active, stall_type, stall_nack;
  apu_rsp_t  rsp;
  reg_addr_t waddr_ret;
  int        pending, returned, checks, errors;
  int        cycle_count, total_errors;
  integer    seed;
  logic [31:0] rnd;
  reg_addr_t recent [4];

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  apu_top #(
    .NUM_REGS_W(NUM_REGS_W)
  ) DUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .enable_i     (enable),
    .apu_req_i    (req),
    .apu_lat_i    (lat),
    .apu_waddr_i  (waddr),
    .rd_query_i   (rd_q),
    .wr_query_i   (wr_q),
    .valid_o      (valid),
    .apu_rsp_o    (rsp),
    .apu_waddr_o  (waddr_ret),
    .read_dep_o   (read_dep),
    .write_dep_o  (write_dep),
    .stall_o      (stall),
    .active_o     (active),
    .stall_type_o (stall_type),
    .stall_nack_o (stall_nack)
  );

  apu_monitor u_mon (
    .clk_i (clk), .rst_ni (rst_n), .done_i (done),
    .enable_i (enable), .req_i (req), .lat_i (lat), .waddr_i (waddr),
    .rd_query_i (rd_q), .wr_query_i (wr_q),
    .valid_i (valid), .rsp_i (rsp), .waddr_ret_i (waddr_ret),
    .read_dep_i (read_dep), .write_dep_i (write_dep), .stall_i (stall),
    .active_i (active), .stall_type_i (stall_type), .stall_nack_i (stall_nack),
    .pending_o (pending), .returned_o (returned),
    .check_count_o (checks), .err_count_o (errors)
  );

  bind apu_disp apu_disp_chk u_disp_chk (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .inflight_valid_i (valid_inflight_q),
    .waiting_valid_i  (valid_waiting_q),
    .rsp_valid_i      (bus_valid_i),
    .bus_req_i        (bus_req_o),
    .bus_gnt_i        (bus_gnt_i)
  );

  // Run length limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycle_count, pending);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Latency class follows the unit
  task automatic drive_instr();
    logic [31:0] r;
    r = $random(seed);
    req.unit        = r[0] ? UNIT_DIV : UNIT_MULT;
    req.flag_signed = r[2];
    if (r[0]) begin
      req.op = r[1] ? OP_REM : OP_DIV;
      lat    = LAT_MULTI;
    end else begin
      req.op = r[1] ? OP_MULH : OP_MUL;
      lat    = LAT_PIPE;
    end
    req.operand_a = $random(seed);
    req.operand_b = $random(seed);
    // Zero and short operands now and then
    if (r[5:3] == 3'd0) begin
      req.operand_b = 32'h0;
    end
    if (r[7:6] == 2'd0) begin
      req.operand_a = {24'h0, req.operand_a[7:0]};
    end
    waddr = r[13:8];
    recent[r[15:14]] = r[13:8];
  endtask

  // Half the query addresses reuse recent destinations
  task automatic drive_queries();
    logic [31:0] r;
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      rd_q.valid[i] = r[0];
      rd_q.addr[i]  = r[1] ? recent[r[3:2]] : r[9:4];
    end
    for (int i = 0; i < 2; i++) begin
      r = $random(seed);
      wr_q.valid[i] = r[0];
      wr_q.addr[i]  = r[1] ? recent[r[3:2]] : r[9:4];
    end
  endtask

  initial begin
    seed        = 32'h806b;
    cycle_count = 0;
    rst_n       = 1'b0;
    enable      = 1'b0;
    done        = 1'b0;
    req         = '0;
    lat         = LAT_SINGLE;
    waddr       = '0;
    rd_q        = '0;
    wr_q        = '0;
    foreach (recent[i]) begin
      recent[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle cycles before the first request
    repeat (3) begin
      drive_queries();
      @(posedge clk);
      #1;
    end
    for (int n = 0; n < NUM_INSTR; n++) begin
      rnd = $random(seed);
      if (rnd[1:0] == 2'd0) begin
        repeat (rnd[3:2]) begin
          drive_queries();
          @(posedge clk);
          #1;
        end
      end
      drive_instr();
      drive_queries();
      enable = 1'b1;
      // Hold the instruction until it is taken
      @(negedge clk);
      while (stall) begin
        @(posedge clk);
        #1;
        drive_queries();
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      enable = 1'b0;
    end
    while (pending != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    done = 1'b1;
    @(posedge clk);
    #1;
    total_errors = errors + DUT.u_disp.u_disp_chk.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures, %0d of %0d returned",
             checks, errors, DUT.u_disp.u_disp_chk.fail_count, returned, NUM_INSTR);
    if (total_errors == 0 && returned == NUM_INSTR) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
